// ==== source/SiFH_defines.svh ====
`ifndef SIFH_DEFINES_SVH
`define SIFH_DEFINES_SVH

// timestamp width
`define Np 10

// timestamp to coarse bin
`define COARSE_SHIFT 4

`define BIN_NUM_PER_HIS 64
`define PIXEL_NUM_PER_RAM 4
`define PIX_BITS 2

// pixel id above bin index
`define RAM_ADDR 8

// count width, saturating
`define peakMax 8

// fine window is three coarse bins
`define WINDOW_BINS 48

`endif

// ==== source/sifhPkg.sv ====
`include "SiFH_defines.svh"

package sifhPkg;

    typedef logic [`Np-1:0] stampT;
    typedef logic [`RAM_ADDR-`PIX_BITS-1:0] binT;  // 6 bits
    typedef logic [`PIX_BITS-1:0] pixelT;
    typedef logic [`RAM_ADDR-1:0] addrT;           // {pixel, bin}
    typedef logic [`peakMax-1:0] countT;

    // window limits, both inclusive
    typedef struct packed {
        stampT thLow;
        stampT thHigh;
    } threshT;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        BUILD,
        DRAIN,
        SCAN,
        DONE
    } phaseT;

endpackage

// ==== source/histRam.sv ====
`timescale 1ns/1ps

module histRam #(
    parameter int DEPTH = 256,
    parameter type wordT = logic [7:0]
) (
    input  logic                     clk,
    input  logic                     wEnable,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  wordT                     wdata,
    input  logic                     rEnable,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output wordT                     rdata
);

    wordT mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (rEnable) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== source/hisBuilder.sv ====
`timescale 1ns/1ps

module hisBuilder (
    input  logic           clk,
    input  logic           res,
    input  logic           clearStart,
    output logic           clearDone,
    input  logic           binValid,
    input  sifhPkg::pixelT binPixel,
    input  sifhPkg::binT   bin,
    output sifhPkg::addrT  raddr,
    output logic           rEnable,
    input  sifhPkg::countT counts,
    output sifhPkg::addrT  waddr,
    output logic           wEnable,
    output sifhPkg::countT newCounts
);

    import sifhPkg::*;

    logic  clearing;
    addrT  clearAddr;

    logic  s1Valid;     // read data on counts
    addrT  s1Addr;
    logic  s2Valid;     // incremented, writing
    addrT  s2Addr;
    countT s2Count;
    logic  s3Valid;     // written on the last edge
    addrT  s3Addr;
    countT s3Count;

    countT baseCount;
    countT incCount;

    // read issued as the bin is accepted
    assign raddr     = {binPixel, bin};
    assign rEnable   = binValid;

    assign clearDone = clearing && (clearAddr == '1);

    // sweep of all addresses, one per cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing  <= 1'b0;
            clearAddr <= '0;
        end else if (clearStart) begin
            clearing  <= 1'b1;
            clearAddr <= '0;
        end else if (clearing) begin
            clearAddr <= clearAddr + 1'b1;
            if (clearDone) begin
                clearing <= 1'b0;
            end
        end
    end

    // newest in-flight count for the same bin wins over the RAM word
    always_comb begin
        if (s2Valid && (s2Addr == s1Addr)) begin
            baseCount = s2Count;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            baseCount = s3Count;
        end else begin
            baseCount = counts;
        end
        incCount = (baseCount == '1) ? baseCount : baseCount + 1'b1;  // saturate at max
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= binValid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr  <= raddr;
        s2Addr  <= s1Addr;
        s2Count <= incCount;
        s3Addr  <= s2Addr;
        s3Count <= s2Count;
    end

    // clear sweep takes the write port
    assign wEnable   = clearing || s2Valid;
    assign waddr     = clearing ? clearAddr : s2Addr;
    assign newCounts = clearing ? '0 : s2Count;

endmodule

// ==== source/peakScan.sv ====
`timescale 1ns/1ps

module peakScan (
    input  logic           clk,
    input  logic           res,
    input  logic           scanStart,
    output sifhPkg::addrT  raddr,
    output logic           rEnable,
    input  sifhPkg::countT counts,
    output logic           pixDone,
    output sifhPkg::pixelT pixel,
    output sifhPkg::binT   peakBin,
    output sifhPkg::countT peakCount
);

    import sifhPkg::*;

    logic  scanning;
    addrT  scanAddr;

    logic  d1Valid;     // counts belong to d1Addr
    addrT  d1Addr;
    pixelT d1Pixel;
    binT   d1Bin;

    countT maxCount;
    binT   maxBin;
    countT nextCount;
    binT   nextBin;

    assign raddr   = scanAddr;
    assign rEnable = scanning;

    assign {d1Pixel, d1Bin} = d1Addr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            scanAddr <= '0;
        end else if (scanStart) begin
            scanning <= 1'b1;
            scanAddr <= '0;
        end else if (scanning) begin
            scanAddr <= scanAddr + 1'b1;
            if (scanAddr == '1) begin
                scanning <= 1'b0;
            end
        end
    end

    // first bin restarts the max, strictly greater keeps the lowest bin on ties
    always_comb begin
        if ((d1Bin == '0) || (counts > maxCount)) begin
            nextCount = counts;
            nextBin   = d1Bin;
        end else begin
            nextCount = maxCount;
            nextBin   = maxBin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            d1Valid <= 1'b0;
            pixDone <= 1'b0;
        end else begin
            d1Valid <= rEnable;
            pixDone <= d1Valid && (d1Bin == '1);  // last bin of the pixel
        end
    end

    always_ff @(posedge clk) begin
        d1Addr <= scanAddr;
        if (d1Valid) begin
            maxCount <= nextCount;
            maxBin   <= nextBin;
        end
        if (d1Valid && (d1Bin == '1)) begin
            pixel     <= d1Pixel;
            peakBin   <= nextBin;
            peakCount <= nextCount;
        end
    end

endmodule

// ==== source/thresholdCalc.sv ====
`timescale 1ns/1ps
`include "SiFH_defines.svh"

module thresholdCalc (
    input  logic            clk,
    input  logic            res,
    input  logic            pixDone,
    input  sifhPkg::pixelT  pixel,
    input  sifhPkg::binT    peakBin,
    input  logic            update,
    output sifhPkg::pixelT  waddr,
    output logic            wEnable,
    output sifhPkg::threshT thresh
);

    import sifhPkg::*;

    binT          coarseLow;
    stampT        lowStamp;
    logic [`Np:0] highWide;   // one spare bit for the top clamp
    stampT        highStamp;

    // window starts one coarse bin below the peak
    always_comb begin
        coarseLow = peakBin - 1'b1;
        if (peakBin == '0) begin
            lowStamp = '0;
        end else begin
            lowStamp = stampT'(coarseLow) << `COARSE_SHIFT;
        end
        highWide = {1'b0, lowStamp} + (`Np+1)'(`WINDOW_BINS - 1);
        // peak in the top coarse bin, window stops at the last timestamp
        highStamp = highWide[`Np] ? '1 : highWide[`Np-1:0];
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wEnable <= 1'b0;
        end else begin
            wEnable <= pixDone && update;
        end
    end

    always_ff @(posedge clk) begin
        if (pixDone && update) begin
            waddr         <= pixel;
            thresh.thLow  <= lowStamp;
            thresh.thHigh <= highStamp;
        end
    end

endmodule

// ==== source/SiFHtop.sv ====
`timescale 1ns/1ps
`include "SiFH_defines.svh"

module SiFHtop (
    input  logic           clk,
    input  logic           res,
    input  logic           start,
    input  logic           dataValid,
    input  sifhPkg::pixelT pixel,
    input  sifhPkg::stampT data,
    input  logic           frameEnd,
    output logic           collecting,
    output logic           resultValid,
    output sifhPkg::pixelT resultPixel,
    output sifhPkg::stampT peakStamp,
    output sifhPkg::countT peakCount,
    output logic           done
);

    import sifhPkg::*;

    phaseT      phase;
    logic       pass;        // low for coarse, high for fine
    logic [1:0] drainCnt;
    logic       drainLast;
    logic       scanLast;
    logic       accept;

    logic       clearStart;
    logic       clearDone;
    logic       binValid;
    pixelT      binPixel;
    binT        bin;
    addrT       bRaddr;
    logic       bREnable;
    addrT       hWaddr;
    logic       hWEnable;
    countT      hWdata;
    addrT       hRaddr;
    logic       hREnable;
    countT      hRdata;

    logic       scanStart;
    addrT       sRaddr;
    logic       sREnable;
    logic       pixDone;
    pixelT      scanPixel;
    binT        scanBin;
    countT      scanCount;

    pixelT      thWaddr;
    logic       thWEnable;
    threshT     thWdata;
    pixelT      thRaddr;
    logic       thREnable;
    threshT     thRdata;

    logic       sValid;      // fine sample waiting on its threshold
    pixelT      sPixel;
    stampT      sData;
    logic       inWindow;
    binT        resBin;

    assign collecting = (phase == BUILD);
    assign accept     = collecting && dataValid;
    assign drainLast  = (drainCnt == (pass ? 2'd3 : 2'd2));  // 3 or 4 cycles
    assign scanLast   = pixDone && (scanPixel == '1);
    assign clearStart = ((phase == IDLE) && start) || ((phase == SCAN) && scanLast && !pass);
    assign scanStart  = (phase == DRAIN) && drainLast;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase    <= IDLE;
            pass     <= 1'b0;
            drainCnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= (phase == DONE);  // one cycle behind the last result
            case (phase)
                IDLE: begin
                    if (start) begin
                        phase <= CLEAR;
                        pass  <= 1'b0;
                    end
                end
                CLEAR: begin
                    if (clearDone) begin
                        phase <= BUILD;
                    end
                end
                BUILD: begin
                    if (frameEnd) begin
                        phase    <= DRAIN;
                        drainCnt <= '0;
                    end
                end
                DRAIN: begin
                    drainCnt <= drainCnt + 1'b1;
                    if (drainLast) begin
                        phase <= SCAN;
                    end
                end
                SCAN: begin
                    if (scanLast) begin
                        phase <= pass ? DONE : CLEAR;
                        pass  <= 1'b1;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    // fine pass waits one cycle for the threshold word
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sValid <= 1'b0;
        end else begin
            sValid <= accept && pass;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sPixel <= pixel;
            sData  <= data;
        end
    end

    assign inWindow = (sData >= thRdata.thLow) && (sData <= thRdata.thHigh);

    always_comb begin
        if (pass) begin
            binValid = sValid && inWindow;
            binPixel = sPixel;
            bin      = binT'(sData - thRdata.thLow);
        end else begin
            binValid = accept;
            binPixel = pixel;
            bin      = binT'(data >> `COARSE_SHIFT);
        end
    end

    // threshold read serves the window test, then the result offset
    assign thREnable = pass && ((phase == SCAN) ? pixDone : accept);
    assign thRaddr   = (phase == SCAN) ? scanPixel : pixel;

    assign hRaddr   = (phase == SCAN) ? sRaddr : bRaddr;
    assign hREnable = (phase == SCAN) ? sREnable : bREnable;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= pixDone && pass && (phase == SCAN);
        end
    end

    always_ff @(posedge clk) begin
        if (pixDone) begin
            resultPixel <= scanPixel;
            resBin      <= scanBin;
            peakCount   <= scanCount;
        end
    end

    assign peakStamp = thRdata.thLow + stampT'(resBin);

    hisBuilder i_hisBuilder (
        .clk        (clk),
        .res        (res),
        .clearStart (clearStart),
        .clearDone  (clearDone),
        .binValid   (binValid),
        .binPixel   (binPixel),
        .bin        (bin),
        .raddr      (bRaddr),
        .rEnable    (bREnable),
        .counts     (hRdata),
        .waddr      (hWaddr),
        .wEnable    (hWEnable),
        .newCounts  (hWdata)
    );

    peakScan i_peakScan (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .raddr     (sRaddr),
        .rEnable   (sREnable),
        .counts    (hRdata),
        .pixDone   (pixDone),
        .pixel     (scanPixel),
        .peakBin   (scanBin),
        .peakCount (scanCount)
    );

    thresholdCalc i_thresholdCalc (
        .clk     (clk),
        .res     (res),
        .pixDone (pixDone),
        .pixel   (scanPixel),
        .peakBin (scanBin),
        .update  ((phase == SCAN) && !pass),
        .waddr   (thWaddr),
        .wEnable (thWEnable),
        .thresh  (thWdata)
    );

    histRam #(
        .DEPTH (`BIN_NUM_PER_HIS * `PIXEL_NUM_PER_RAM),
        .wordT (countT)
    ) i_histMem (
        .clk     (clk),
        .wEnable (hWEnable),
        .waddr   (hWaddr),
        .wdata   (hWdata),
        .rEnable (hREnable),
        .raddr   (hRaddr),
        .rdata   (hRdata)
    );

    histRam #(
        .DEPTH (`PIXEL_NUM_PER_RAM),
        .wordT (threshT)
    ) i_threshMem (
        .clk     (clk),
        .wEnable (thWEnable),
        .waddr   (thWaddr),
        .wdata   (thWdata),
        .rEnable (thREnable),
        .raddr   (thRaddr),
        .rdata   (thRdata)
    );

endmodule

// ==== dv/tbSiFH.sv ====
`timescale 1ns/1ps
`include "SiFH_defines.svh"

module tbSiFH;

    import sifhPkg::*;

    localparam int numEntries = 5;
    localparam int numPix     = `PIXEL_NUM_PER_RAM;
    localparam int numBins    = `BIN_NUM_PER_HIS;
    localparam int maxStamp   = (1 << `Np) - 1;
    localparam int countMax   = (1 << `peakMax) - 1;
    localparam int maxSamples = 4096;

    logic  clk;
    logic  res;
    logic  start;
    logic  dataValid;
    pixelT pixel;
    stampT data;
    logic  frameEnd;
    logic  collecting;
    logic  resultValid;
    pixelT resultPixel;
    stampT peakStamp;
    countT peakCount;
    logic  done;

    // one frame per entry
    int peakTab  [numEntries][numPix];
    int countTab [numEntries][numPix];
    int noiseTab [numEntries];
    int decoyTab [numEntries];    // offered while collecting is low
    bit burstTab [numEntries];

    int framePix [maxSamples];
    int frameTs  [maxSamples];
    int frameLen;
    int expStamp [numPix];
    int expCount [numPix];

    int seed       = 80;
    int cycles     = 0;
    int cycleLimit = 0;
    int e;

    SiFHtop i_dut (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .dataValid   (dataValid),
        .pixel       (pixel),
        .data        (data),
        .frameEnd    (frameEnd),
        .collecting  (collecting),
        .resultValid (resultValid),
        .resultPixel (resultPixel),
        .peakStamp   (peakStamp),
        .peakCount   (peakCount),
        .done        (done)
    );

    always #5 clk = ~clk;

    task automatic failStop();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic stopRun(input string what);
        $display("Error at %0t: %s", $time, what);
        failStop();
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if ((cycleLimit > 0) && (cycles > cycleLimit)) begin
            stopRun($sformatf("timeout, no end of run within %0d cycles", cycleLimit));
        end
    end

    task automatic checkPixel(input string name, input pixelT expected, input pixelT actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            failStop();
        end
    endtask

    task automatic checkStamp(input string name, input stampT expected, input stampT actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            failStop();
        end
    endtask

    task automatic checkCount(input string name, input countT expected, input countT actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            failStop();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            failStop();
        end
    endtask

    task automatic setEntry(input int n, input int p0, c0, p1, c1, p2, c2, p3, c3,
                            input int noise, decoy, input bit burst);
        peakTab[n]  = '{p0, p1, p2, p3};
        countTab[n] = '{c0, c1, c2, c3};
        noiseTab[n] = noise;
        decoyTab[n] = decoy;
        burstTab[n] = burst;
    endtask

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // far outside pixel 0's window, same fine bin as its peak modulo 64
    function automatic int decoyStamp(input int n);
        return (peakTab[n][0] + 512) % (maxStamp + 1);
    endfunction

    // saturated peaks get a twin one stamp higher, so two bins tie at the max
    function automatic int frameLength(input int n);
        int len;
        len = noiseTab[n];
        for (int p = 0; p < numPix; p++) begin
            len += (countTab[n][p] > countMax) ? 2 * countTab[n][p] : countTab[n][p];
        end
        if (decoyTab[n] > 0) begin
            len += countTab[n][0] / 2;
        end
        return len;
    endfunction

    function automatic int entryCycles(input int n);
        return 2 * frameLength(n) + 2 * 256 + 2 * 260 + 50;
    endfunction

    task automatic addSample(input int p, input int ts);
        framePix[frameLen] = p;
        frameTs[frameLen]  = ts;
        frameLen++;
    endtask

    task automatic buildFrame(input int n);
        int j;
        int tmpPix;
        int tmpTs;
        int twin;
        frameLen = 0;
        for (int p = 0; p < numPix; p++) begin
            twin = (peakTab[n][p] < maxStamp) ? peakTab[n][p] + 1 : peakTab[n][p] - 1;
            for (int k = 0; k < countTab[n][p]; k++) begin
                addSample(p, peakTab[n][p]);   // contiguous, same pixel and bin
            end
            if (countTab[n][p] > countMax) begin
                for (int k = 0; k < countTab[n][p]; k++) begin
                    addSample(p, twin);
                end
            end
        end
        if (decoyTab[n] > 0) begin
            for (int k = 0; k < countTab[n][0] / 2; k++) begin
                addSample(0, decoyStamp(n));   // loses the coarse pass
            end
        end
        for (int k = 0; k < noiseTab[n]; k++) begin
            addSample(randBelow(numPix), randBelow(maxStamp + 1));
        end
        if (!burstTab[n]) begin
            for (int i = frameLen - 1; i > 0; i--) begin   // shuffle
                j = randBelow(i + 1);
                tmpPix = framePix[i];
                tmpTs = frameTs[i];
                framePix[i] = framePix[j];
                frameTs[i] = frameTs[j];
                framePix[j] = tmpPix;
                frameTs[j] = tmpTs;
            end
        end
    endtask

    // reference model of both passes
    task automatic computeExpected();
        int coarse [numPix][numBins];
        int fine   [numPix][numBins];
        int thLow  [numPix];
        int thHigh [numPix];
        int best;
        int p;
        int b;
        for (p = 0; p < numPix; p++) begin
            for (b = 0; b < numBins; b++) begin
                coarse[p][b] = 0;
                fine[p][b] = 0;
            end
        end
        for (int i = 0; i < frameLen; i++) begin
            b = frameTs[i] >> `COARSE_SHIFT;
            if (coarse[framePix[i]][b] < countMax) coarse[framePix[i]][b]++;
        end
        for (p = 0; p < numPix; p++) begin
            best = 0;
            for (b = 1; b < numBins; b++) begin
                if (coarse[p][b] > coarse[p][best]) best = b;   // lowest bin on ties
            end
            thLow[p] = (best == 0) ? 0 : (best - 1) * (1 << `COARSE_SHIFT);
            thHigh[p] = thLow[p] + `WINDOW_BINS - 1;
            if (thHigh[p] > maxStamp) thHigh[p] = maxStamp;
        end
        for (int i = 0; i < frameLen; i++) begin
            p = framePix[i];
            if ((frameTs[i] >= thLow[p]) && (frameTs[i] <= thHigh[p])) begin
                b = frameTs[i] - thLow[p];
                if (fine[p][b] < countMax) fine[p][b]++;
            end
        end
        for (p = 0; p < numPix; p++) begin
            best = 0;
            for (b = 1; b < numBins; b++) begin
                if (fine[p][b] > fine[p][best]) best = b;
            end
            expStamp[p] = thLow[p] + best;
            expCount[p] = fine[p][best];
        end
    endtask

    // decoys go in only while collecting is low, all on one bin of pixel 0
    task automatic waitCollecting(input int decoyN, input int decoyTs);
        int sent;
        sent = 0;
        while (!collecting) begin
            dataValid = (sent < decoyN);
            pixel = '0;
            data = stampT'(decoyTs);
            sent++;
            @(negedge clk);
        end
        dataValid = 1'b0;
    endtask

    task automatic streamFrame(input int n, input bit endFrame);
        for (int i = 0; i < n; i++) begin
            checkFlag("collecting", 1'b1, collecting);
            dataValid = 1'b1;
            pixel = pixelT'(framePix[i]);
            data = stampT'(frameTs[i]);
            @(negedge clk);
        end
        dataValid = 1'b0;
        if (endFrame) begin
            frameEnd = 1'b1;
            @(negedge clk);
            frameEnd = 1'b0;
        end
    endtask

    task automatic collectResults();
        int got;
        int waited;
        got = 0;
        waited = 0;
        while (!done) begin
            if (resultValid && (got < numPix)) begin
                checkPixel("resultPixel", pixelT'(got), resultPixel);
                checkStamp("peakStamp", stampT'(expStamp[got]), peakStamp);
                checkCount("peakCount", countT'(expCount[got]), peakCount);
                got++;
            end else if (resultValid) begin
                stopRun("more results than pixels in one run");
            end
            waited++;
            if (waited > 320) begin   // drain plus one full scan
                stopRun("done did not arrive after the second scan");
            end
            @(negedge clk);
        end
        if (got != numPix) begin
            stopRun($sformatf("done arrived after %0d results instead of %0d", got, numPix));
        end
    endtask

    task automatic runEntry(input int n, input bit abort);
        int decoyTs;
        buildFrame(n);
        computeExpected();
        decoyTs = decoyStamp(n);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        waitCollecting(decoyTab[n], decoyTs);
        if (abort) begin
            streamFrame(frameLen / 2, 1'b0);
        end else begin
            streamFrame(frameLen, 1'b1);
            waitCollecting(decoyTab[n], decoyTs);
            streamFrame(frameLen, 1'b1);
            collectResults();
        end
    endtask

    task automatic checkQuiet();
        checkFlag("collecting", 1'b0, collecting);
        checkFlag("resultValid", 1'b0, resultValid);
        checkFlag("done", 1'b0, done);
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        start = 1'b0;
        dataValid = 1'b0;
        pixel = '0;
        data = '0;
        frameEnd = 1'b0;

        setEntry(0, 100, 30, 300, 30, 600, 30, 900, 30, 20, 0, 1'b0);
        setEntry(1, 3, 40, 1020, 40, 520, 25, 9, 25, 12, 0, 1'b0);       // edges
        setEntry(2, 200, 300, 450, 20, 700, 260, 60, 20, 16, 0, 1'b0);   // saturation
        setEntry(3, 333, 120, 333, 90, 77, 200, 999, 60, 10, 0, 1'b1);   // bursts
        setEntry(4, 400, 30, 150, 30, 820, 30, 610, 30, 40, 150, 1'b0);  // decoys

        // aborted and clean rerun of entry 0 come on top
        cycleLimit = 2 * entryCycles(0) + 20;
        for (e = 0; e < numEntries; e++) begin
            cycleLimit += entryCycles(e);
        end
        cycleLimit = cycleLimit + cycleLimit / 4;

        repeat (10) @(negedge clk);
        checkQuiet();
        res = 1'b1;
        @(negedge clk);
        checkQuiet();

        for (e = 0; e < numEntries; e++) begin
            runEntry(e, 1'b0);
        end

        // reset in the middle of the first collection
        runEntry(0, 1'b1);
        res = 1'b0;
        repeat (10) @(negedge clk);
        checkQuiet();
        res = 1'b1;
        @(negedge clk);
        checkQuiet();
        runEntry(0, 1'b0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+source
source/sifhPkg.sv
source/histRam.sv
source/hisBuilder.sv
source/peakScan.sv
source/thresholdCalc.sv
source/SiFHtop.sv
dv/tbSiFH.sv
